//--- Bender.yml
package:
  name: datapath

sources:
  - logic/isaPkg.sv
  - logic/pipePkg.sv
  - logic/creditFifo.sv
  - logic/decodeStage.sv
  - logic/operandStage.sv
  - logic/executeStage.sv
  - logic/datapathTop.sv

  - target: test
    files:
      - sim/tbClock.sv
      - sim/datapathAssert.sv
      - sim/tbTop.sv

  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/datapathAssert.sv
      - sim/tbTop.sv

//--- filelist.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/creditFifo.sv
logic/decodeStage.sv
logic/operandStage.sv
logic/executeStage.sv
logic/datapathTop.sv
sim/tbClock.sv
sim/datapathAssert.sv
sim/tbTop.sv

//--- logic/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
	parameter int InDepth = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                push,
	input  pipePkg::issueEntryT pushEntry,
	input  logic                pop,
	output pipePkg::issueEntryT popEntry,
	output logic                empty,
	output logic                inCredit
);
	import pipePkg::*;

	localparam int ptrWidth = (InDepth > 1) ? $clog2(InDepth) : 1;
	localparam int cntWidth = $clog2(InDepth + 1);

	issueEntryT            mem [InDepth];   // Entry storage
	logic [ptrWidth-1:0]   wrPtr;
	logic [ptrWidth-1:0]   rdPtr;
	logic [cntWidth-1:0]   count;           // Entries held
	logic                  popOk;

	// Wrap at InDepth so odd depths work too
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(InDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty    = (count == '0);
	assign popOk    = pop && !empty;    // Ignore a pop on an empty queue
	assign popEntry = mem[rdPtr];       // Head is visible before the pop

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushEntry;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			inCredit <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (popOk)
				rdPtr <= nextPtr(rdPtr);
			case ({push, popOk})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
			inCredit <= popOk;   // One credit back per freed slot
		end
	end

endmodule

//--- logic/datapathTop.sv
`timescale 1ns/1ps

module datapathTop #(
	parameter int InDepth    = 4,
	parameter int OutCredits = 2
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            instrValid,
	input  pipePkg::wordT   instrWord,
	input  pipePkg::wordT   memData,
	output logic            inCredit,
	input  logic            resultCredit,
	output logic            resultValid,
	output pipePkg::regIdxT resultIndex,
	output logic            resultWrite,
	output pipePkg::wordT   resultData,
	output pipePkg::flagsT  resultFlags
);
	import isaPkg::*;
	import pipePkg::*;

	localparam int countWidth = $clog2(OutCredits + 1);

	issueEntryT pushEntry;
	issueEntryT popEntry;
	logic       empty;
	logic       issue;
	logic [countWidth-1:0] outCount;   // Results not yet absorbed downstream

	logic   decValid, decWrite;
	opcodeT decOpcode;
	regIdxT decA, decB, decDest;
	wordT   decMem;
	logic   opValid, opWrite;
	opcodeT opOpcode;
	wordT   opA, opB, opMem;
	regIdxT opImmField, opDest;
	logic   exValid, wbEnable;
	regIdxT exIndex, wbIndex;
	wordT   exData, wbData;

	assign pushEntry = '{instr: instrWord, memData: memData};

	// Issue only when the consumer is sure to have room
	assign issue = !empty && (outCount < countWidth'(OutCredits));

	always_ff @(posedge clk)
	begin
		if (!reset)
			outCount <= '0;
		else
			case ({issue, resultCredit})
				2'b10:   outCount <= outCount + 1'b1;
				2'b01:   outCount <= outCount - 1'b1;
				default: outCount <= outCount;
			endcase
	end

	creditFifo #(.InDepth(InDepth)) u_fifo (
		.clk, .reset, .push(instrValid), .pushEntry, .pop(issue), .popEntry,
		.empty, .inCredit
	);

	decodeStage u_decode (
		.clk, .reset, .issue, .instrWord(popEntry.instr), .memData(popEntry.memData),
		.decValid, .decOpcode, .decA, .decB, .decDest, .decWrite, .decMem
	);

	operandStage u_operand (
		.clk, .reset, .decValid, .decOpcode, .decA, .decB, .decDest, .decWrite, .decMem,
		.exValid, .exIndex, .exData, .wbEnable, .wbIndex, .wbData,
		.opValid, .opOpcode, .opA, .opB, .opImmField, .opDest, .opWrite, .opMem
	);

	executeStage u_execute (
		.clk, .reset, .opValid, .opOpcode, .opA, .opB, .opImmField, .opDest, .opWrite,
		.opMem, .exValid, .exIndex, .exData, .wbEnable, .wbIndex, .wbData,
		.resultValid, .resultIndex, .resultWrite, .resultData, .resultFlags
	);

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic            clk,
	input  logic            reset,
	input  logic            issue,
	input  pipePkg::wordT   instrWord,
	input  pipePkg::wordT   memData,
	output logic            decValid,
	output isaPkg::opcodeT  decOpcode,
	output pipePkg::regIdxT decA,
	output pipePkg::regIdxT decB,
	output pipePkg::regIdxT decDest,
	output logic            decWrite,
	output pipePkg::wordT   decMem
);
	import isaPkg::*;
	import pipePkg::*;

	opcodeT opcode;
	regIdxT fieldA;
	regIdxT fieldB;
	logic   writes;

	// Field split
	assign opcode = instrWord[opcodeMsb:opcodeLsb];
	assign fieldA = instrWord[fieldAMsb:fieldALsb];
	assign fieldB = instrWord[fieldBMsb:fieldBLsb];

	// Which opcodes write the bank
	always_comb
	begin
		case (opcode)
			CMP, CMPI, CMPU, NOP, STORE:
				writes = 1'b0;                    // Flags only or nothing
			ADD, ADDI, ADDU, ADDUI, ADDC, ADDCU, ADDCUI, ADDCI, SUB, SUBI,
			AND, OR, XOR, NOT, LSH, LSHI, RSH, RSHI, ALSH, ARSH, LOAD:
				writes = 1'b1;
			default:
				writes = 1'b0;                    // Unknown opcode
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			decValid <= 1'b0;
		else
			decValid <= issue;
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			decOpcode <= opcode;
			decA      <= fieldA;
			decB      <= fieldB;
			decDest   <= (opcode == LOAD) ? fieldB : fieldA;  // LOAD targets B
			decWrite  <= writes;
			decMem    <= memData;
		end
	end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic            clk,
	input  logic            reset,
	input  logic            opValid,
	input  isaPkg::opcodeT  opOpcode,
	input  pipePkg::wordT   opA,
	input  pipePkg::wordT   opB,
	input  pipePkg::regIdxT opImmField,
	input  pipePkg::regIdxT opDest,
	input  logic            opWrite,
	input  pipePkg::wordT   opMem,
	output logic            exValid,
	output pipePkg::regIdxT exIndex,
	output pipePkg::wordT   exData,
	output logic            wbEnable,
	output pipePkg::regIdxT wbIndex,
	output pipePkg::wordT   wbData,
	output logic            resultValid,
	output pipePkg::regIdxT resultIndex,
	output logic            resultWrite,
	output pipePkg::wordT   resultData,
	output pipePkg::flagsT  resultFlags
);
	import isaPkg::*;
	import pipePkg::*;

	flagsT       flagReg;    // Z C F L N
	logic        carryIn;
	logic [16:0] sum;        // Shared adder with carry out
	wordT        diff;
	logic        addOver;
	logic        subOver;
	logic        signedLess;
	logic [3:0]  shAmt;
	wordT        aluOut;
	flagsT       aluFlags;
	wordT        exResult;

	// Carry family uses the flag from the previous instruction
	assign carryIn = (opOpcode inside {ADDC, ADDCU, ADDCUI, ADDCI}) ? flagReg[flagCarry] : 1'b0;
	assign sum     = {1'b0, opA} + {1'b0, opB} + 17'(carryIn);
	assign diff    = opA - opB;
	assign addOver = (opA[15] == opB[15]) && (sum[15] != opA[15]);
	assign subOver = (opA[15] != opB[15]) && (diff[15] != opA[15]);
	assign signedLess = $signed(opA) < $signed(opB);

	always_comb
	begin
		shAmt = (opOpcode inside {LSHI, RSHI}) ? opImmField : opB[3:0];
		if (shAmt == '0)
			shAmt = 4'd1;    // Zero means shift by one
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		aluOut   = '0;
		aluFlags = '0;   // Logic, shift and unknown opcodes leave all clear
		case (opOpcode)
			ADD, ADDI, ADDC:
			begin
				aluOut             = sum[15:0];
				aluFlags[flagOver] = addOver;
			end
			ADDU, ADDUI, ADDCU, ADDCUI:
			begin
				aluOut              = sum[15:0];
				aluFlags[flagCarry] = sum[16];
			end
			ADDCI:      aluOut = sum[15:0];
			SUB, SUBI:
			begin
				aluOut             = diff;
				aluFlags[flagOver] = subOver;
			end
			CMP, CMPI:
			begin
				aluFlags[flagLow]  = signedLess;
				aluFlags[flagNeg]  = signedLess;
				aluFlags[flagZero] = (opA == opB);
			end
			CMPU:
			begin
				aluFlags[flagLow]  = (opA < opB);
				aluFlags[flagZero] = (opA == opB);
			end
			AND:        aluOut = opA & opB;
			OR:         aluOut = opA | opB;
			XOR:        aluOut = opA ^ opB;
			NOT:        aluOut = ~opA;
			LSH, LSHI, ALSH: aluOut = opA << shAmt;
			RSH, RSHI:  aluOut = opA >> shAmt;                  // Zero filled
			ARSH:       aluOut = wordT'($signed(opA) >>> shAmt);
			default:    aluOut = '0;                            // NOP, STORE, LOAD
		endcase
		// Zero flag for the add and subtract families
		if (opOpcode inside {ADD, ADDI, ADDU, ADDUI, ADDC, ADDCU, ADDCUI, ADDCI, SUB, SUBI})
			aluFlags[flagZero] = (aluOut == '0);
	end

	assign exResult = (opOpcode == LOAD) ? opMem : aluOut;   // Load select

	// Bypass toward operand read
	assign exValid = opValid && opWrite;
	assign exIndex = opDest;
	assign exData  = exResult;

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			flagReg     <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= opValid;
			if (opValid)
				flagReg <= aluFlags;   // Every valid instruction updates
		end
	end

	always_ff @(posedge clk)
	begin
		if (opValid)
		begin
			resultIndex <= opDest;
			resultWrite <= opWrite;
			resultData  <= exResult;
		end
	end

	assign resultFlags = flagReg;
	assign wbEnable    = resultValid && resultWrite;   // Bank written at this edge
	assign wbIndex     = resultIndex;
	assign wbData      = resultData;

endmodule

//--- logic/isaPkg.sv
package isaPkg;

	typedef logic [7:0] opcodeT;   // Upper byte of the instruction word

	////////////////////////////////////////////////////////////////////////////
	// Opcode encodings
	////////////////////////////////////////////////////////////////////////////
	localparam opcodeT ADD    = 8'b0000_0000;
	localparam opcodeT ADDI   = 8'b0000_0001;  // Signed immediate
	localparam opcodeT ADDU   = 8'b0000_0010;
	localparam opcodeT ADDUI  = 8'b0000_0011;
	localparam opcodeT ADDC   = 8'b0000_0100;  // Adds in the carry flag
	localparam opcodeT ADDCU  = 8'b0000_0101;
	localparam opcodeT ADDCUI = 8'b0000_0110;
	localparam opcodeT ADDCI  = 8'b0000_0111;
	localparam opcodeT SUB    = 8'b0000_1000;
	localparam opcodeT SUBI   = 8'b0000_1001;
	localparam opcodeT CMP    = 8'b0000_1010;  // Signed compare
	localparam opcodeT CMPI   = 8'b0000_1011;
	localparam opcodeT CMPU   = 8'b0000_1100;  // Unsigned compare
	localparam opcodeT AND    = 8'b0000_1101;
	localparam opcodeT OR     = 8'b0000_1110;
	localparam opcodeT XOR    = 8'b0000_1111;
	localparam opcodeT NOT    = 8'b0001_0000;
	localparam opcodeT LSH    = 8'b0001_0001;
	localparam opcodeT LSHI   = 8'b0001_0010;
	localparam opcodeT RSH    = 8'b0001_0011;  // Logical right
	localparam opcodeT RSHI   = 8'b0001_0100;
	localparam opcodeT ALSH   = 8'b0001_0101;
	localparam opcodeT ARSH   = 8'b0001_0110;  // Sign filled
	localparam opcodeT NOP    = 8'b0001_0111;
	localparam opcodeT STORE  = 8'b1101_1010;
	localparam opcodeT LOAD   = 8'b1001_1001;

	// Bit positions inside the flag vector
	localparam int flagZero  = 4;
	localparam int flagCarry = 3;
	localparam int flagOver  = 2;
	localparam int flagLow   = 1;
	localparam int flagNeg   = 0;

	localparam int numRegs = 16;   // Size of the register bank

	// Instruction word layout
	localparam int opcodeMsb = 15;
	localparam int opcodeLsb = 8;
	localparam int fieldAMsb = 7;
	localparam int fieldALsb = 4;
	localparam int fieldBMsb = 3;
	localparam int fieldBLsb = 0;

endpackage

//--- logic/operandStage.sv
`timescale 1ns/1ps

module operandStage (
	input  logic            clk,
	input  logic            reset,
	input  logic            decValid,
	input  isaPkg::opcodeT  decOpcode,
	input  pipePkg::regIdxT decA,
	input  pipePkg::regIdxT decB,
	input  pipePkg::regIdxT decDest,
	input  logic            decWrite,
	input  pipePkg::wordT   decMem,
	input  logic            exValid,
	input  pipePkg::regIdxT exIndex,
	input  pipePkg::wordT   exData,
	input  logic            wbEnable,
	input  pipePkg::regIdxT wbIndex,
	input  pipePkg::wordT   wbData,
	output logic            opValid,
	output isaPkg::opcodeT  opOpcode,
	output pipePkg::wordT   opA,
	output pipePkg::wordT   opB,
	output pipePkg::regIdxT opImmField,
	output pipePkg::regIdxT opDest,
	output logic            opWrite,
	output pipePkg::wordT   opMem
);
	import isaPkg::*;
	import pipePkg::*;

	wordT bank [numRegs];   // Register bank
	wordT regA;
	wordT regB;
	wordT operandB;         // B after immediate select

	// Newest value wins, execute result then writeback then bank
	function automatic wordT readPort(input regIdxT idx);
		if (exValid && exIndex == idx)
			return exData;
		if (wbEnable && wbIndex == idx)
			return wbData;
		return bank[idx];
	endfunction

	always_comb
	begin
		regA = readPort(decA);
		regB = readPort(decB);
	end

	////////////////////////////////////////////////////////////////////////////
	// Immediate select
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		case (decOpcode)
			ADDI, ADDCI:                          operandB = wordT'($signed(decB));
			ADDUI, ADDCUI, SUBI, CMPI, LSHI, RSHI: operandB = wordT'(decB);  // Zero ext
			default:                              operandB = regB;
		endcase
	end

	// Write port, driven by the execute register
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			for (int i = 0; i < numRegs; i++)
				bank[i] <= '0;
		end
		else if (wbEnable)
			bank[wbIndex] <= wbData;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			opValid <= 1'b0;
		else
			opValid <= decValid;
	end

	always_ff @(posedge clk)
	begin
		if (decValid)
		begin
			opOpcode   <= decOpcode;
			opA        <= regA;
			opB        <= operandB;
			opImmField <= decB;     // Raw field for immediate shifts
			opDest     <= decDest;
			opWrite    <= decWrite;
			opMem      <= decMem;
		end
	end

endmodule

//--- logic/pipePkg.sv
package pipePkg;

	// Datapath word
	typedef logic [15:0] wordT;

	// Index into the sixteen entry bank
	typedef logic [3:0] regIdxT;

	// Flag vector
	// Bit 4 Z, bit 3 C, bit 2 F, bit 1 L, bit 0 N
	typedef logic [4:0] flagsT;

	////////////////////////////////////////////////////////////////////////////
	// Queue entry
	////////////////////////////////////////////////////////////////////////////
	// One instruction as it waits in the issue queue
	typedef struct packed
	{
		wordT instr;     // Raw instruction word
		wordT memData;   // Data word a LOAD writes
	} issueEntryT;

endpackage

//--- sim/datapathAssert.sv
`timescale 1ns/1ps

module datapathAssert #(
	parameter int InDepth    = 4,
	parameter int CountWidth = 2
) (
	input logic                  clk,
	input logic                  reset,
	input logic                  push,
	input logic                  issue,
	input logic                  inCredit,
	input logic [CountWidth-1:0] outCount,
	input logic                  resultValid,
	input logic                  wbEnable
);

	int held;           // Queue entries, counted from the push and pop strobes
	int failures = 0;   // Assertion failures so far

	always_ff @(posedge clk)
	begin
		if (!reset)
			held <= 0;
		else
			held <= held + int'(push) - int'(issue);
	end

	// A credit only ever follows a pop by one cycle
	creditFollowsPop: assert property (@(posedge clk) disable iff (!reset)
		inCredit |-> $past(issue))
		else
		begin
			$error("inCredit seen without a pop one cycle earlier");
			failures++;
		end

	// Upstream never pushes into a full queue
	noOverflow: assert property (@(posedge clk) disable iff (!reset)
		push |-> (held < InDepth || issue))
		else
		begin
			$error("push into a full instruction queue");
			failures++;
		end

	// Every result on the bus is one the counter accounts for
	resultHasRoom: assert property (@(posedge clk) disable iff (!reset)
		resultValid |-> (outCount != '0))
		else
		begin
			$error("result presented with no consumer credit taken");
			failures++;
		end

	// Bank writes only with a visible result
	writeNeedsResult: assert property (@(posedge clk) disable iff (!reset)
		wbEnable |-> resultValid)
		else
		begin
			$error("wbEnable high while resultValid is low");
			failures++;
		end

endmodule

//--- sim/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int HalfPeriod  = 5,   // 10 ns clock
	parameter int ResetCycles = 5
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
			#HalfPeriod clk = ~clk;
	end

	// Active low, released just after an edge
	initial
	begin
		reset = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#1;
		reset = 1'b1;
	end

endmodule

//--- sim/tbTop.sv
`timescale 1ns/1ps

module tbTop;
	import isaPkg::*;
	import pipePkg::*;

	localparam int InDepth     = 4;
	localparam int OutCredits  = 3;     // Room for three rows in flight at once
	localparam int numRows     = 31;
	localparam int waitLimit   = 100;   // Cycles any one wait may take
	localparam int drainCycles = 8;     // Quiet cycles watched after the last row

	logic   clk;
	logic   reset;
	logic   instrValid;
	wordT   instrWord;
	wordT   memData;
	logic   inCredit;
	logic   resultCredit;
	logic   resultValid;
	regIdxT resultIndex;
	logic   resultWrite;
	wordT   resultData;
	flagsT  resultFlags;

	// Stimulus and expected values, one entry per row
	string  rowName  [numRows];
	wordT   rowInstr [numRows];
	wordT   rowMem   [numRows];
	logic   rowWrite [numRows];
	regIdxT rowIndex [numRows];
	wordT   rowData  [numRows];
	flagsT  rowFlags [numRows];
	int     rowCount = 0;

	int   creditsBack = 0;   // Input credits returned so far
	int   pushCount   = 0;
	int   cycleNo     = 0;
	int   lastDue     = 0;   // Cycle of the newest scheduled consumer credit
	int   dueQ [$];          // Pending consumer credits, by cycle
	int   resultsSeen = 0;
	int   passCount   = 0;
	int   failCount   = 0;
	int   extraCount  = 0;
	logic timedOut    = 1'b0;

	tbClock clockGen (.clk, .reset);

	datapathTop #(.InDepth(InDepth), .OutCredits(OutCredits)) dut (
		.clk, .reset, .instrValid, .instrWord, .memData, .inCredit, .resultCredit,
		.resultValid, .resultIndex, .resultWrite, .resultData, .resultFlags
	);

	bind datapathTop datapathAssert #(.InDepth(InDepth), .CountWidth(countWidth)) checks (
		.clk(clk), .reset(reset), .push(instrValid), .issue(issue), .inCredit(inCredit),
		.outCount(outCount), .resultValid(resultValid), .wbEnable(wbEnable)
	);

	always @(posedge clk)
	begin
		if (reset && inCredit)
			creditsBack <= creditsBack + 1;   // One slot freed upstream
	end

	function automatic wordT instrOf(input opcodeT op, input regIdxT a, input regIdxT b);
		return {op, a, b};
	endfunction

	task automatic addRow(input string name, input opcodeT op, input regIdxT a,
		input regIdxT b, input wordT mem, input logic wr, input regIdxT idx,
		input wordT data, input flagsT flags);
		rowName[rowCount]  = name;
		rowInstr[rowCount] = instrOf(op, a, b);
		rowMem[rowCount]   = mem;
		rowWrite[rowCount] = wr;
		rowIndex[rowCount] = idx;
		rowData[rowCount]  = data;
		rowFlags[rowCount] = flags;
		rowCount++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Table, flags as Z C F L N
	////////////////////////////////////////////////////////////////////////////
	task automatic loadTable();
		addRow("load r1", LOAD, 4'd0, 4'd1, 16'h0005, 1'b1, 4'd1, 16'h0005, 5'b00000);
		addRow("load r2", LOAD, 4'd0, 4'd2, 16'h7fff, 1'b1, 4'd2, 16'h7fff, 5'b00000);
		addRow("load r3", LOAD, 4'd0, 4'd3, 16'hffff, 1'b1, 4'd3, 16'hffff, 5'b00000);
		addRow("add ovf", ADD, 4'd1, 4'd2, 16'h0000, 1'b1, 4'd1, 16'h8004, 5'b00100);
		addRow("addu cy", ADDU, 4'd3, 4'd1, 16'h0000, 1'b1, 4'd3, 16'h8003, 5'b01000);
		addRow("addc cin", ADDC, 4'd2, 4'd1, 16'h0000, 1'b1, 4'd2, 16'h0004, 5'b00000);
		addRow("sub zero", SUB, 4'd2, 4'd2, 16'h0000, 1'b1, 4'd2, 16'h0000, 5'b10000);
		addRow("subi", SUBI, 4'd1, 4'd3, 16'h0000, 1'b1, 4'd1, 16'h8001, 5'b00000);
		addRow("addi neg", ADDI, 4'd4, 4'hf, 16'h0000, 1'b1, 4'd4, 16'hffff, 5'b00000);
		addRow("addui dep", ADDUI, 4'd4, 4'd2, 16'h0000, 1'b1, 4'd4, 16'h0001, 5'b01000);
		addRow("addcui dep", ADDCUI, 4'd4, 4'd0, 16'h0000, 1'b1, 4'd4, 16'h0002, 5'b00000);
		addRow("addci", ADDCI, 4'd5, 4'd7, 16'h0000, 1'b1, 4'd5, 16'h0007, 5'b00000);
		addRow("add bypass", ADD, 4'd5, 4'd4, 16'h0000, 1'b1, 4'd5, 16'h0009, 5'b00000);
		addRow("cmp less", CMP, 4'd1, 4'd3, 16'h0000, 1'b0, 4'd1, 16'h0000, 5'b00011);
		addRow("cmpi eq", CMPI, 4'd5, 4'd9, 16'h0000, 1'b0, 4'd5, 16'h0000, 5'b10000);
		addRow("cmpu less", CMPU, 4'd5, 4'd3, 16'h0000, 1'b0, 4'd5, 16'h0000, 5'b00010);
		addRow("and", AND, 4'd3, 4'd5, 16'h0000, 1'b1, 4'd3, 16'h0001, 5'b00000);
		addRow("or", OR, 4'd3, 4'd1, 16'h0000, 1'b1, 4'd3, 16'h8001, 5'b00000);
		addRow("xor", XOR, 4'd3, 4'd4, 16'h0000, 1'b1, 4'd3, 16'h8003, 5'b00000);
		addRow("not", NOT, 4'd6, 4'd0, 16'h0000, 1'b1, 4'd6, 16'hffff, 5'b00000);
		addRow("lshi by0", LSHI, 4'd5, 4'd0, 16'h0000, 1'b1, 4'd5, 16'h0012, 5'b00000);
		addRow("rshi", RSHI, 4'd6, 4'd4, 16'h0000, 1'b1, 4'd6, 16'h0fff, 5'b00000);
		addRow("lsh", LSH, 4'd1, 4'd4, 16'h0000, 1'b1, 4'd1, 16'h0004, 5'b00000);
		addRow("arsh", ARSH, 4'd3, 4'd4, 16'h0000, 1'b1, 4'd3, 16'he000, 5'b00000);
		addRow("rsh", RSH, 4'd3, 4'd5, 16'h0000, 1'b1, 4'd3, 16'h3800, 5'b00000);
		addRow("alsh", ALSH, 4'd6, 4'd4, 16'h0000, 1'b1, 4'd6, 16'h3ffc, 5'b00000);
		addRow("store", STORE, 4'd6, 4'd1, 16'h1234, 1'b0, 4'd6, 16'h0000, 5'b00000);
		addRow("nop", NOP, 4'd0, 4'd0, 16'h0000, 1'b0, 4'd0, 16'h0000, 5'b00000);
		addRow("add self", ADD, 4'd6, 4'd6, 16'h0000, 1'b1, 4'd6, 16'h7ff8, 5'b00000);
		addRow("unknown", 8'h20, 4'd6, 4'd0, 16'h0000, 1'b0, 4'd6, 16'h0000, 5'b00000);
		addRow("add r0", ADD, 4'd6, 4'd0, 16'h0000, 1'b1, 4'd6, 16'h7ff8, 5'b00000);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic checkWord(input string name, input wordT exp, input wordT act,
		inout logic ok);
		if (act !== exp)
		begin
			$display("ERR %s data expected %h actual %h", name, exp, act);
			ok = 1'b0;
		end
	endtask

	task automatic checkFlags(input string name, input flagsT exp, input flagsT act,
		inout logic ok);
		if (act !== exp)
		begin
			$display("ERR %s flags expected %b actual %b", name, exp, act);
			ok = 1'b0;
		end
	endtask

	task automatic checkIndex(input string name, input regIdxT exp, input regIdxT act,
		inout logic ok);
		if (act !== exp)
		begin
			$display("ERR %s index expected %0d actual %0d", name, exp, act);
			ok = 1'b0;
		end
	endtask

	task automatic checkWrite(input string name, input logic exp, input logic act,
		inout logic ok);
		if (act !== exp)
		begin
			$display("ERR %s write expected %b actual %b", name, exp, act);
			ok = 1'b0;
		end
	endtask

	task automatic checkRow(input int i);
		logic ok;
		ok = 1'b1;
		checkWrite(rowName[i], rowWrite[i], resultWrite, ok);
		checkIndex(rowName[i], rowIndex[i], resultIndex, ok);
		checkWord(rowName[i], rowData[i], resultData, ok);
		checkFlags(rowName[i], rowFlags[i], resultFlags, ok);
		if (ok)
		begin
			passCount++;
			$display("ok   %s", rowName[i]);
		end
		else
		begin
			failCount++;
			$display("bad  %s", rowName[i]);
		end
	endtask

	// Upstream side, pushes only while holding a credit
	task automatic sendRows();
		int waited;
		for (int i = 0; i < rowCount && !timedOut; i++)
		begin
			waited = 0;
			while (InDepth + creditsBack - pushCount <= 0)
			begin
				instrValid = 1'b0;
				if (waited == waitLimit)
				begin
					$display("Upstream waited too long for an input credit at row %0d", i);
					timedOut = 1'b1;
					return;
				end
				@(posedge clk);
				#1;
				waited++;
			end
			instrValid = 1'b1;
			instrWord  = rowInstr[i];
			memData    = rowMem[i];
			pushCount++;
			@(posedge clk);
			#1;
		end
		instrValid = 1'b0;
	endtask

	// Pulses resultCredit when the oldest scheduled credit is due
	task automatic returnCredit();
		resultCredit = 1'b0;
		if (dueQ.size() > 0 && dueQ[0] <= cycleNo)
		begin
			resultCredit = 1'b1;
			void'(dueQ.pop_front());
		end
	endtask

	// Consumer side, checks results in table order
	task automatic collectResults();
		int idle;
		int due;
		idle = 0;
		while (resultsSeen < rowCount && !timedOut)
		begin
			@(posedge clk);
			#1;
			cycleNo++;
			if (resultValid)
			begin
				checkRow(resultsSeen);
				resultsSeen++;
				due = cycleNo + int'($urandom_range(3, 0));   // 0 to 3 cycles later
				if (due <= lastDue)
					due = lastDue + 1;
				lastDue = due;
				dueQ.push_back(due);
				idle = 0;
			end
			else if (idle == waitLimit)
			begin
				$display("No result for row %0d within %0d cycles", resultsSeen, waitLimit);
				timedOut = 1'b1;
			end
			else
				idle++;
			returnCredit();
		end
		// Anything after the last row is a stray result
		for (int k = 0; k < drainCycles && !timedOut; k++)
		begin
			@(posedge clk);
			#1;
			cycleNo++;
			if (resultValid)
			begin
				extraCount++;
				$display("Result beyond the last row appeared, index %0d", resultIndex);
			end
			returnCredit();
		end
		resultCredit = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		int waited;
		void'($urandom(61));
		instrValid   = 1'b0;
		instrWord    = '0;
		memData      = '0;
		resultCredit = 1'b0;
		loadTable();
		waited = 0;
		while (reset !== 1'b1 && waited < waitLimit)   // Hold until reset lifts
		begin
			@(posedge clk);
			waited++;
		end
		if (reset !== 1'b1)
		begin
			$display("Reset was never released");
			timedOut = 1'b1;
		end
		else
		begin
			@(posedge clk);
			#1;
			fork
				sendRows();
				collectResults();
			join
		end
		$display("Rows %0d, results %0d, passed %0d, failed %0d, extra %0d, assertions %0d",
			rowCount, resultsSeen, passCount, failCount, extraCount, dut.checks.failures);
		if (timedOut || failCount != 0 || extraCount != 0 || resultsSeen != rowCount
			|| dut.checks.failures != 0)
			$display("Test failed");
		else
			$display("Test completed successfully");
		$finish;
	end

endmodule
